// ==== test/tx_frame_golden.hex ====
// six rows per frame: status in bits 39:0, samples 0+1, samples 2+3, expected words 0-7,
// expected words 8-15, then words 16-19 in bits 127:64 with the sof mask in bits 19:0
// frame 0: ptt only, alc form
00000000000000000000008123112233
A000B001C002D003A010B011C012D013
A020B021C022D023A030B031C032D033
7F7F7F0501231133A000B001C002D003
A010B011C012D013A020B021C022D023
A030B031C032D0330000000000080000
// frame 1: dot only with overload, merc form
00000000000000000000005456445566
A100B101C102D103A110B111C112D113
A120B121C122D123A130B131C132D133
7F7F7F0101554466A100B101C102D103
A110B111C112D113A120B121C122D123
A130B131C132D1330000000000080000
// frame 2: dash only, alc form
00000000000000000000002ABC778899
A200B201C202D203A210B211C212D213
A220B221C222D223A230B231C232D233
7F7F7F060ABC7799A200B201C202D203
A210B211C212D213A220B221C222D223
A230B231C232D2330000000000080000
// frame 3: no keys, merc form
00000000000000000000000FEDA1B2C3
A300B301C302D303A310B311C312D313
A320B321C322D323A330B331C332D333
7F7F7F0000B2A1C3A300B301C302D303
A310B311C312D313A320B321C322D323
A330B331C332D3330000000000080000
// frame 4: ptt and dash with overload, alc form
0000000000000000000000B0F05A6B7C
A400B401C402D403A410B411C412D413
A420B421C422D423A430B431C432D433
7F7F7F0700F05A7CA400B401C402D403
A410B411C412D413A420B421C422D423
A430B431C432D4330000000000080000
// frame 5: dot and dash with overload, merc form
00000000000000000000007321C4D5E6
A500B501C502D503A510B511C512D513
A520B521C522D523A530B531C532D533
7F7F7F0301D5C4E6A500B501C502D503
A510B511C512D513A520B521C522D523
A530B531C532D5330000000000080000

// ==== sources.f ====
verilog/frame_pkg.sv
verilog/frame_builder.sv
verilog/word_fifo.sv
verilog/beat_packer.sv
verilog/tx_frame_top.sv
test/tx_frame_assert.sv
test/tx_frame_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tx_frame_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tx_frame_tb.sv ====
// drives tx_frame_top with six frames of four sample groups read from the golden file
// the golden row layout is described at the top of that file
// out_ready stalls and sample_rdy gaps come from $urandom with a fixed seed
// the header that follows the last expected frame is not checked
module tx_frame_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import frame_pkg::*;

  localparam int NUM_LOOPS    = 4;
  localparam int FIFO_DEPTH   = 16;
  localparam int NUM_FRAMES   = 6;
  localparam int ROWS         = 6;                                   // golden rows per frame
  localparam int FRAME_WORDS  = HDR_WORDS + NUM_LOOPS * GROUP_WORDS; // 20 words
  localparam int TOTAL_WORDS  = NUM_FRAMES * FRAME_WORDS;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = TOTAL_WORDS * 8 + RESET_CYCLES + SETTLE_CYCLES;
  localparam logic [31:0] SEED = 32'he944_e70a;

  logic    IFCLK = 1'b0;
  logic    IF_reset;
  status_t status;
  sample_t sample;
  logic    sample_rdy;
  beat_t   out_beat;
  logic    out_valid;
  logic    out_ready;

  logic [127:0] golden [NUM_FRAMES*ROWS];          // raw rows from the file
  status_t      status_mem [NUM_FRAMES];
  sample_t      sample_mem [NUM_FRAMES*NUM_LOOPS];
  logic [15:0]  exp_word [TOTAL_WORDS];            // expected word stream
  logic         exp_sof [TOTAL_WORDS];

  int word_cnt    = 0;   // words accepted at the output
  int settle_seen = 0;   // saturating count of cycles since reset release
  int cycle_cnt   = 0;

  tx_frame_top #(
    .NUM_LOOPS  (NUM_LOOPS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) tx_frame_top_i (
    .IFCLK      (IFCLK),
    .IF_reset   (IF_reset),
    .status     (status),
    .sample     (sample),
    .sample_rdy (sample_rdy),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  always #50 IFCLK = ~IFCLK;   // 100 ns period

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected)
    begin
      $display("ERR %0t: %s: got %h, expected %h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // split golden rows into status, samples and expected words
  task automatic load_golden();
    int f;
    int w;
    $readmemh("test/tx_frame_golden.hex", golden);
    for (f = 0; f < NUM_FRAMES; f++)
    begin
      status_mem[f]               = status_t'(golden[f*ROWS][39:0]);
      sample_mem[f*NUM_LOOPS]     = golden[f*ROWS+1][127:64];
      sample_mem[f*NUM_LOOPS + 1] = golden[f*ROWS+1][63:0];
      sample_mem[f*NUM_LOOPS + 2] = golden[f*ROWS+2][127:64];
      sample_mem[f*NUM_LOOPS + 3] = golden[f*ROWS+2][63:0];
      for (w = 0; w < FRAME_WORDS; w++)
      begin
        exp_word[f*FRAME_WORDS + w] = golden[f*ROWS + 3 + w/8][127 - 16*(w%8) -: 16];
        exp_sof[f*FRAME_WORDS + w]  = golden[f*ROWS + 5][19 - w];   // sof mask with word 0 at msb
      end
    end
  endtask

  // offer each sample, drop sample_rdy once its words have come out as beats
  task automatic send_samples();
    int f;
    int s;
    int gap;
    int target;
    for (f = 0; f < NUM_FRAMES; f++)
      for (s = 0; s < NUM_LOOPS; s++)
      begin
        gap = $urandom_range(1, 4);            // at least one low cycle
        repeat (gap) @(posedge IFCLK);
        sample     <= sample_mem[f*NUM_LOOPS + s];
        sample_rdy <= 1'b1;
        target = f*FRAME_WORDS + HDR_WORDS + (s + 1)*GROUP_WORDS;
        while (word_cnt < target)
          @(posedge IFCLK);
        sample_rdy <= 1'b0;
        if (s == NUM_LOOPS - 1 && f < NUM_FRAMES - 1)
          status <= status_mem[f + 1];         // frame drained so the next header may use it
      end
  endtask

  task automatic stall_ready();
    forever
    begin
      @(posedge IFCLK);
      out_ready <= ($urandom_range(0, 3) != 0);   // ready about 3 cycles in 4
    end
  endtask

  ////////////////////////////////////////////////////////////
  // scoreboard and cycle limit
  ////////////////////////////////////////////////////////////

  always @(posedge IFCLK)
  begin
    if (IF_reset)
    begin
      settle_seen <= 0;
      if (cycle_cnt > 0)                       // reset has had one edge to act
        check(64'(out_valid), 64'(0), "out_valid during reset");
    end
    else if (settle_seen < SETTLE_CYCLES)
    begin
      settle_seen <= settle_seen + 1;
      check(64'(out_valid), 64'(0), "out_valid before the first frame");
    end
    else if (out_valid && out_ready && word_cnt < TOTAL_WORDS)
    begin
      check(64'(out_beat),
            64'({exp_word[word_cnt], exp_word[word_cnt + 1], exp_sof[word_cnt]}),
            $sformatf("beat at word %0d", word_cnt));
      word_cnt <= word_cnt + 2;
    end
  end

  always @(posedge IFCLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("CHECKS FAILED");
      $fatal(1, "timeout: the expected beats did not arrive within %0d cycles", CYCLE_LIMIT);
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    IF_reset   = 1'b1;
    status     = '0;
    sample     = '0;
    sample_rdy = 1'b0;
    out_ready  = 1'b0;
    load_golden();
    status = status_mem[0];                    // first frame's status
    repeat (RESET_CYCLES) @(posedge IFCLK);
    IF_reset <= 1'b0;
    fork
      stall_ready();
    join_none
    send_samples();
    @(posedge IFCLK);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== test/tx_frame_assert.sv ====
// concurrent checks on the credit loop and the output hold
// bound into tx_frame_top, reaching the builder credit counter and the FIFO count
module tx_frame_assert #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                IFCLK,
  input  logic                                IF_reset,
  input  logic [$clog2(FIFO_DEPTH + 1) - 1:0] credits,
  input  logic [$clog2(FIFO_DEPTH + 1) - 1:0] count,
  input  logic                                credit_ret,
  input  logic                                wr_en,
  input  frame_pkg::beat_t                    out_beat,
  input  logic                                out_valid,
  input  logic                                out_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  // credit_ret high means one credit is on its way back
  credit_balance: assert property (@(posedge IFCLK) disable iff (IF_reset)
    int'(credits) + int'(count) + int'(credit_ret) == FIFO_DEPTH)
    else $error("credit count and FIFO occupancy do not add up to the depth");

  no_write_full: assert property (@(posedge IFCLK) disable iff (IF_reset)
    wr_en |-> (int'(count) < FIFO_DEPTH))
    else $error("FIFO written while full");

  beat_hold: assert property (@(posedge IFCLK) disable iff (IF_reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else $error("output beat changed while stalled");

endmodule

bind tx_frame_top tx_frame_assert #(
  .FIFO_DEPTH (FIFO_DEPTH)
) assert_i (
  .IFCLK      (IFCLK),
  .IF_reset   (IF_reset),
  .credits    (builder_i.credits),
  .count      (fifo_i.count),
  .credit_ret (credit_ret),
  .wr_en      (wr_en),
  .out_beat   (out_beat),
  .out_valid  (out_valid),
  .out_ready  (out_ready)
);

// ==== verilog/tx_frame_top.sv ====
// builder, credit FIFO and beat packer for the upstream host link
// NUM_LOOPS sets the sample groups per frame
// FIFO_DEPTH must be at least 8 so a header and a group can both be credited
module tx_frame_top #(
  parameter int NUM_LOOPS  = 63,
  parameter int FIFO_DEPTH = 16
) (
  input  logic               IFCLK,
  input  logic               IF_reset,
  input  frame_pkg::status_t status,
  input  frame_pkg::sample_t sample,
  input  logic               sample_rdy,
  output frame_pkg::beat_t   out_beat,
  output logic               out_valid,
  input  logic               out_ready
);
  import frame_pkg::*;

  logic        wr_en;        // builder to FIFO
  frame_word_t wr_word;
  logic        credit_ret;   // FIFO back to builder
  logic        rd_valid;     // FIFO head to packer
  frame_word_t rd_word;
  logic        rd_en;

  frame_builder #(
    .NUM_LOOPS  (NUM_LOOPS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) builder_i (
    .IFCLK      (IFCLK),
    .IF_reset   (IF_reset),
    .status     (status),
    .sample     (sample),
    .sample_rdy (sample_rdy),
    .credit_ret (credit_ret),
    .wr_en      (wr_en),
    .wr_word    (wr_word)
  );

  word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .IFCLK      (IFCLK),
    .IF_reset   (IF_reset),
    .wr_en      (wr_en),
    .wr_word    (wr_word),
    .rd_en      (rd_en),
    .rd_valid   (rd_valid),
    .rd_word    (rd_word),
    .credit_ret (credit_ret)
  );

  beat_packer packer_i (
    .IFCLK      (IFCLK),
    .IF_reset   (IF_reset),
    .rd_valid   (rd_valid),
    .rd_word    (rd_word),
    .rd_en      (rd_en),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

// ==== verilog/beat_packer.sv ====
// packs pairs of frame words into 32-bit beats, first word in the upper half
// a beat is held until out_ready is seen high on a rising edge
// frames have an even word count, so sof can only arrive on a first word
module beat_packer (
  input  logic                   IFCLK,
  input  logic                   IF_reset,
  input  logic                   rd_valid,
  input  frame_pkg::frame_word_t rd_word,
  output logic                   rd_en,
  output frame_pkg::beat_t       out_beat,
  output logic                   out_valid,
  input  logic                   out_ready
);
  import frame_pkg::*;

  frame_word_t half_word;    // first word of the pair, with its sof
  logic        half_valid;
  logic        out_free;     // output register empty or draining now

  assign out_free = !out_valid || out_ready;

  // first word can always be taken; second only if the beat has somewhere to go
  assign rd_en = rd_valid && (!half_valid || out_free);

  ////////////////////////////////////////////////////////////
  // half beat and output beat
  ////////////////////////////////////////////////////////////

  always_ff @(posedge IFCLK)
  begin
    if (rd_en && !half_valid)
      half_word <= rd_word;
    if (rd_en && half_valid)
    begin
      out_beat.data <= {half_word.data, rd_word.data};
      out_beat.sof  <= half_word.sof;
    end
  end

  always_ff @(posedge IFCLK)
  begin
    if (IF_reset)
    begin
      half_valid <= 1'b0;
      out_valid  <= 1'b0;
    end
    else
    begin
      if (rd_en)
        half_valid <= ~half_valid;   // alternates first and second word

      if (rd_en && half_valid)
        out_valid <= 1'b1;           // new beat, also replaces one leaving now
      else if (out_ready)
        out_valid <= 1'b0;
    end
  end

endmodule

// ==== verilog/word_fifo.sv ====
// circular buffer of frame words with a show-ahead head
// no full flag: the writer holds one credit per free entry
// each pop returns a credit on the following cycle
// depth need not be a power of two
module word_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                   IFCLK,
  input  logic                   IF_reset,
  input  logic                   wr_en,
  input  frame_pkg::frame_word_t wr_word,
  input  logic                   rd_en,
  output logic                   rd_valid,
  output frame_pkg::frame_word_t rd_word,
  output logic                   credit_ret
);
  import frame_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  frame_word_t       mem [FIFO_DEPTH];   // word storage
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;              // words held
  logic              pop;

  // pointer step with wrap at FIFO_DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign rd_valid = (count != '0);
  assign rd_word  = mem[rd_ptr];         // head is visible without a read
  assign pop      = rd_en && rd_valid;   // ignore pops on empty

  always_ff @(posedge IFCLK)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge IFCLK)
  begin
    if (IF_reset)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);

      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // idle, or push and pop together
      endcase

      credit_ret <= pop;                 // one credit per word removed
    end
  end

endmodule

// ==== verilog/frame_builder.sv ====
// the sample source must hold sample_rdy and sample steady until all four
// words are written, then drop sample_rdy before offering the next set
// status is read live during the header, so change it only between frames
// writes start only with enough credits, so the FIFO never overflows
module frame_builder #(
  parameter int NUM_LOOPS  = 63,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                   IFCLK,
  input  logic                   IF_reset,
  input  frame_pkg::status_t     status,
  input  frame_pkg::sample_t     sample,
  input  logic                   sample_rdy,
  input  logic                   credit_ret,
  output logic                   wr_en,
  output frame_pkg::frame_word_t wr_word
);
  import frame_pkg::*;

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);
  localparam int LOOP_W = (NUM_LOOPS > 1) ? $clog2(NUM_LOOPS) : 1;
  localparam int SET_W  = $clog2(SETTLE_CYCLES + 1);

  typedef enum logic [2:0] {
    ST_SETTLE,     // idle after reset
    ST_HDR_WAIT,   // wait for header credits
    ST_HDR,        // sync and control words
    ST_GRP_WAIT,   // wait for sample_rdy and group credits
    ST_GRP,        // four sample words
    ST_DROP,       // wait for sample_rdy to go low
    ST_LOOP        // next group or next frame
  } state_t;

  state_t              state;
  state_t              state_next;
  logic [SET_W-1:0]    settle_cnt;   // settle timer
  logic [1:0]          word_idx;     // word within header or group
  logic [LOOP_W-1:0]   loop_cnt;     // groups sent in this frame
  logic [CRED_W-1:0]   credits;      // free FIFO entries we may claim
  logic                frame_flag;   // picks control word form, toggles per frame

  ////////////////////////////////////////////////////////////
  // state, counters and credits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge IFCLK)
  begin
    if (IF_reset)
    begin
      state      <= ST_SETTLE;
      settle_cnt <= '0;
      word_idx   <= '0;
      loop_cnt   <= '0;
      credits    <= CRED_W'(FIFO_DEPTH);   // whole buffer is free
      frame_flag <= 1'b1;                  // first frame sends the alc form
    end
    else
    begin
      state <= state_next;

      if (state == ST_SETTLE)
        settle_cnt <= settle_cnt + 1'b1;

      if (wr_en)
        word_idx <= word_idx + 1'b1;       // wraps to 0 after the fourth word

      if (state == ST_HDR && word_idx == 2'(HDR_WORDS - 1))
        frame_flag <= ~frame_flag;          // after the last header word

      if (state == ST_HDR_WAIT)
        loop_cnt <= '0;                     // new frame
      else if (state == ST_LOOP)
        loop_cnt <= loop_cnt + 1'b1;

      // one word out, one credit back, or both in the same cycle
      case ({wr_en, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // next state and write word
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    wr_en      = 1'b0;
    wr_word    = '0;
    case (state)
      ST_SETTLE:
        if (settle_cnt == SET_W'(SETTLE_CYCLES - 1))
          state_next = ST_HDR_WAIT;

      ST_HDR_WAIT:
        if (credits >= CRED_W'(HDR_WORDS))   // whole header fits
          state_next = ST_HDR;

      ST_HDR:
      begin
        wr_en = 1'b1;
        case (word_idx)
          2'd0:
          begin
            wr_word.data = SYNC_WORD;
            wr_word.sof  = 1'b1;              // frame start
          end
          2'd1:
            wr_word.data = {8'h7F, 5'b0, frame_flag, status.dash,
                            status.dot | status.ptt};
          2'd2:
            if (frame_flag)
              wr_word.data = {4'b0, status.alc};
            else
              wr_word.data = {7'b0, status.adc_overload, status.merc_serial};
          default:
            wr_word.data = {status.penny_serial, status.ozy_serial};
        endcase
        if (word_idx == 2'(HDR_WORDS - 1))
          state_next = ST_GRP_WAIT;
      end

      ST_GRP_WAIT:
        if (sample_rdy && credits >= CRED_W'(GROUP_WORDS))
          state_next = ST_GRP;

      ST_GRP:
      begin
        wr_en = 1'b1;
        case (word_idx)
          2'd0:    wr_word.data = sample.left_hi;
          2'd1:    wr_word.data = sample.left_lo_right_hi;
          2'd2:    wr_word.data = sample.right_lo;
          default: wr_word.data = sample.mic;
        endcase
        if (word_idx == 2'(GROUP_WORDS - 1))
          state_next = ST_DROP;
      end

      ST_DROP:
        if (!sample_rdy)                      // source has seen the words go out
          state_next = ST_LOOP;

      ST_LOOP:
        if (loop_cnt == LOOP_W'(NUM_LOOPS - 1))
          state_next = ST_HDR_WAIT;           // frame done
        else
          state_next = ST_GRP_WAIT;

      default:
        state_next = ST_SETTLE;
    endcase
  end

endmodule

// ==== verilog/frame_pkg.sv ====
// shared types and constants for the upstream frame path
// a frame is HDR_WORDS words, then NUM_LOOPS groups of GROUP_WORDS words
// sof is set only on the first sync word of each frame
package frame_pkg;

  ////////////////////////////////////////////////////////////
  // frame constants
  ////////////////////////////////////////////////////////////

  localparam logic [15:0] SYNC_WORD     = 16'h7F7F; // both sync bytes
  localparam int          HDR_WORDS     = 4;        // sync, sync+flags, two control words
  localparam int          GROUP_WORDS   = 4;        // words per IQ/mic sample set
  localparam int          SETTLE_CYCLES = 32;       // idle after reset before first frame

  ////////////////////////////////////////////////////////////
  // payload structs
  ////////////////////////////////////////////////////////////

  // per-frame status, sampled while the header goes out
  typedef struct packed {
    logic        ptt;           // debounced PTT
    logic        dot;           // debounced dot paddle
    logic        dash;          // debounced dash paddle
    logic        adc_overload;
    logic [11:0] alc;           // ALC reading from the exciter
    logic [7:0]  penny_serial;
    logic [7:0]  merc_serial;
    logic [7:0]  ozy_serial;
  } status_t;

  // one IQ/mic sample set, sent most significant field first
  typedef struct packed {
    logic [15:0] left_hi;
    logic [15:0] left_lo_right_hi;
    logic [15:0] right_lo;
    logic [15:0] mic;
  } sample_t;

  typedef struct packed {
    logic [15:0] data;
    logic        sof;           // first sync word of a frame
  } frame_word_t;

  typedef struct packed {
    logic [31:0] data;          // first word in the upper half
    logic        sof;
  } beat_t;

endpackage
